//--- hdl/switch_info_pkg.sv
// Shared widths and types for the switch-info memory; user DATA_NBITS must not exceed PIO_NBITS
package switch_info_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int FID_NBITS      = 2;  // Flow id
	localparam int IDX_NBITS      = 6;  // Entry index within a flow
	localparam int CMD_ADDR_NBITS = 12; // PU command address
	localparam int PIO_NBITS      = 32; // Host address and data

	// Region code expected in addr[11:8] of a PU command
	localparam logic [3:0] REGION_SWITCH_INFO = 4'h2;

	////////////////////
	// PU command
	////////////////////
	// Memory address is fid followed by addr[5:0]; addr[7:6] unused
	typedef struct packed {
		logic [FID_NBITS-1:0]      fid;
		logic [CMD_ADDR_NBITS-1:0] addr;
	} io_cmd_t;

	////////////////////
	// Host PIO port
	////////////////////
	typedef enum logic [1:0] {
		PIO_IDLE  = 2'd0,
		PIO_READ  = 2'd1,
		PIO_WRITE = 2'd2
	} pio_op_e;

	typedef struct packed {
		pio_op_e              op;
		logic                 sel;  // Memory select
		logic [PIO_NBITS-1:0] addr;
		logic [PIO_NBITS-1:0] din;
	} pio_req_t;

	typedef struct packed {
		logic                 ack;
		logic [PIO_NBITS-1:0] rdata;
	} pio_rsp_t;

endpackage

//--- hdl/pu_req_latch.sv
// One pending read per PU; a PU must not strobe again before its acknowledge arrives
`timescale 1ns/1ps

module pu_req_latch #(
	parameter int NUM_PU = 4,
	localparam int PU_ID_NBITS = $clog2(NUM_PU)
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [NUM_PU-1:0]        io_req,
	input  switch_info_pkg::io_cmd_t io_cmd [NUM_PU],
	input  logic                     gnt,
	input  logic [PU_ID_NBITS-1:0]   gnt_sel,
	output logic [NUM_PU-1:0]        pend,
	output switch_info_pkg::io_cmd_t cmd_q [NUM_PU]
);

	logic [NUM_PU-1:0] set_pend; // Strobed and inside the region
	logic [NUM_PU-1:0] clr_pend; // Granted this cycle

	////////////////////
	// Region decode
	////////////////////
	always_comb begin
		for (int i = 0; i < NUM_PU; i++) begin
			set_pend[i] = io_req[i] &&
				(io_cmd[i].addr[11:8] == switch_info_pkg::REGION_SWITCH_INFO);
			clr_pend[i] = gnt && (gnt_sel == PU_ID_NBITS'(i));
		end
	end

	// Pending flags, grant clears on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= '0;
		end else begin
			for (int i = 0; i < NUM_PU; i++) begin
				if (clr_pend[i])
					pend[i] <= 1'b0;
				else if (set_pend[i])
					pend[i] <= 1'b1;
			end
		end
	end

	// Command capture
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_PU; i++)
			if (set_pend[i])
				cmd_q[i] <= io_cmd[i];
	end

endmodule

//--- hdl/pu_rr_arbiter.sv
// Combinational round-robin grant over NUM_PU requesters; NUM_PU must be at least 2
`timescale 1ns/1ps

module pu_rr_arbiter #(
	parameter int NUM_PU = 4,
	localparam int PU_ID_NBITS = $clog2(NUM_PU)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [NUM_PU-1:0]      req,
	output logic                   gnt,
	output logic [PU_ID_NBITS-1:0] gnt_sel
);

	logic [PU_ID_NBITS-1:0] ptr; // Highest priority PU

	assign gnt = |req;

	////////////////////
	// Winner search
	////////////////////
	always_comb begin : pick
		int   idx;
		logic found;
		found   = 1'b0;
		gnt_sel = '0;
		// Scan starting at the pointer, wrapping around
		for (int k = 0; k < NUM_PU; k++) begin
			idx = (int'(ptr) + k) % NUM_PU;
			if (!found && req[idx]) begin
				found   = 1'b1;
				gnt_sel = PU_ID_NBITS'(idx);
			end
		end
	end

	// Move priority to the PU after the winner
	always_ff @(posedge clk) begin
		if (rst)
			ptr <= '0;
		else if (gnt)
			ptr <= (gnt_sel == PU_ID_NBITS'(NUM_PU - 1)) ? '0 : gnt_sel + 1'b1;
	end

endmodule

//--- hdl/switch_info_ram.sv
// Two-port switch-info array; PU read takes two edges, host ack one; a colliding PU read sees old data
`timescale 1ns/1ps

module switch_info_ram #(
	parameter int DATA_NBITS  = 32,
	parameter int DEPTH_NBITS = 8
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rd,
	input  logic [DEPTH_NBITS-1:0]    raddr,
	output logic                      rd_valid,
	output logic [DATA_NBITS-1:0]     rd_data,
	input  switch_info_pkg::pio_req_t pio_req,
	output switch_info_pkg::pio_rsp_t pio_rsp
);

	logic [DATA_NBITS-1:0] mem [2**DEPTH_NBITS];

	logic                   rd_q;    // Address stage valid
	logic [DEPTH_NBITS-1:0] raddr_q; // Address stage

	logic                   pio_rd;
	logic                   pio_wr;
	logic [DEPTH_NBITS-1:0] pio_addr;

	////////////////////
	// PU read port
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_q     <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_q     <= rd;
			rd_valid <= rd_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rd)
			raddr_q <= raddr;
		if (rd_q)
			rd_data <= mem[raddr_q]; // Old word on a same-edge host write
	end

	////////////////////
	// Host PIO port
	////////////////////
	assign pio_rd   = pio_req.sel && (pio_req.op == switch_info_pkg::PIO_READ);
	assign pio_wr   = pio_req.sel && (pio_req.op == switch_info_pkg::PIO_WRITE);
	assign pio_addr = pio_req.addr[DEPTH_NBITS-1:0];

	always_ff @(posedge clk) begin
		if (pio_wr)
			mem[pio_addr] <= pio_req.din[DATA_NBITS-1:0];
	end

	// Ack one edge after the request, write returns zero
	always_ff @(posedge clk) begin
		if (rst) begin
			pio_rsp <= '0;
		end else begin
			pio_rsp.ack <= pio_rd || pio_wr;
			if (pio_rd)
				pio_rsp.rdata <= switch_info_pkg::PIO_NBITS'(mem[pio_addr]);
			else
				pio_rsp.rdata <= '0;
		end
	end

endmodule

//--- hdl/pu_resp_router.sv
// Routes RAM read data to the granted PU; PU id pipe is two deep to match the RAM latency
`timescale 1ns/1ps

module pu_resp_router #(
	parameter int NUM_PU     = 4,
	parameter int DATA_NBITS = 32,
	localparam int PU_ID_NBITS = $clog2(NUM_PU)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   gnt,
	input  logic [PU_ID_NBITS-1:0] gnt_sel,
	input  logic                   rd_valid,
	input  logic [DATA_NBITS-1:0]  rd_data,
	output logic [NUM_PU-1:0]      io_ack,
	output logic [DATA_NBITS-1:0]  io_ack_data [NUM_PU]
);

	logic [PU_ID_NBITS-1:0] sel_d1; // With the RAM address stage
	logic [PU_ID_NBITS-1:0] sel_d2; // With the RAM data stage

	////////////////////
	// PU id pipe
	////////////////////
	always_ff @(posedge clk) begin
		if (gnt)
			sel_d1 <= gnt_sel;
		sel_d2 <= sel_d1;
	end

	////////////////////
	// Ack demux
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			io_ack <= '0;
			for (int i = 0; i < NUM_PU; i++)
				io_ack_data[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_PU; i++) begin
				if (rd_valid && (sel_d2 == PU_ID_NBITS'(i))) begin
					io_ack[i]      <= 1'b1;
					io_ack_data[i] <= rd_data;
				end else begin
					io_ack[i]      <= 1'b0;
					io_ack_data[i] <= '0; // Zero while not acked
				end
			end
		end
	end

endmodule

//--- hdl/pu_switch_info_mem.sv
// Switch-info lookup memory top; DEPTH_NBITS must equal FID_NBITS + IDX_NBITS and NUM_PU at least 2
`timescale 1ns/1ps

module pu_switch_info_mem #(
	parameter int NUM_PU      = 4,
	parameter int DATA_NBITS  = 32,
	parameter int DEPTH_NBITS = 8,
	localparam int PU_ID_NBITS = $clog2(NUM_PU)
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [NUM_PU-1:0]         io_req,
	input  switch_info_pkg::io_cmd_t  io_cmd [NUM_PU],
	output logic [NUM_PU-1:0]         io_ack,
	output logic [DATA_NBITS-1:0]     io_ack_data [NUM_PU],
	input  switch_info_pkg::pio_req_t pio_req,
	output switch_info_pkg::pio_rsp_t pio_rsp
);

	logic [NUM_PU-1:0]        pend;
	switch_info_pkg::io_cmd_t cmd_q [NUM_PU];

	logic                   gnt;
	logic [PU_ID_NBITS-1:0] gnt_sel;
	logic [DEPTH_NBITS-1:0] raddr;

	logic                  rd_valid;
	logic [DATA_NBITS-1:0] rd_data;

	////////////////////
	// Request side
	////////////////////
	pu_req_latch #(.NUM_PU(NUM_PU)) i_req_latch (
		.clk     (clk),
		.rst     (rst),
		.io_req  (io_req),
		.io_cmd  (io_cmd),
		.gnt     (gnt),
		.gnt_sel (gnt_sel),
		.pend    (pend),
		.cmd_q   (cmd_q)
	);

	pu_rr_arbiter #(.NUM_PU(NUM_PU)) i_arbiter (
		.clk     (clk),
		.rst     (rst),
		.req     (pend),
		.gnt     (gnt),
		.gnt_sel (gnt_sel)
	);

	// Flow id over entry index
	assign raddr = {cmd_q[gnt_sel].fid, cmd_q[gnt_sel].addr[switch_info_pkg::IDX_NBITS-1:0]};

	////////////////////
	// Memory and return
	////////////////////
	switch_info_ram #(
		.DATA_NBITS  (DATA_NBITS),
		.DEPTH_NBITS (DEPTH_NBITS)
	) i_ram (
		.clk      (clk),
		.rst      (rst),
		.rd       (gnt),
		.raddr    (raddr),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.pio_req  (pio_req),
		.pio_rsp  (pio_rsp)
	);

	pu_resp_router #(
		.NUM_PU     (NUM_PU),
		.DATA_NBITS (DATA_NBITS)
	) i_router (
		.clk         (clk),
		.rst         (rst),
		.gnt         (gnt),
		.gnt_sel     (gnt_sel),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.io_ack      (io_ack),
		.io_ack_data (io_ack_data)
	);

endmodule

//--- tb/tb_clk_gen.sv
// Testbench clock of 8 ns with rst held high over the first two rising edges
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tb/tb_pu_switch_info_mem.sv
// Directed tests for the switch-info memory; NUM_PU at most 4 since fids are tied to PU ids
`timescale 1ns/1ps

module tb_pu_switch_info_mem;

	localparam int NUM_PU      = 4;
	localparam int DATA_NBITS  = 32;
	localparam int FID_NB      = switch_info_pkg::FID_NBITS;
	localparam int IDX_NB      = switch_info_pkg::IDX_NBITS;
	localparam int DEPTH_NBITS = FID_NB + IDX_NB;
	localparam int MEM_WORDS   = 2**DEPTH_NBITS;
	localparam int LAT         = 4;           // Uncontended PU latency
	localparam int MAX_LAT     = LAT + NUM_PU - 1;
	localparam int WIN         = MAX_LAT + 3; // Ack watch window
	localparam int N_SINGLE    = 8;
	localparam int N_ROUNDS    = 50;
	localparam int CYCLE_LIMIT = 2 * (4 * MEM_WORDS + (NUM_PU * N_SINGLE + 8 + 2 * NUM_PU)
		* (WIN + 1) + N_ROUNDS * (MAX_LAT + 2) + 4);
	localparam logic [NUM_PU-1:0] ONE_PU = NUM_PU'(1);

	logic                      clk;
	logic                      rst;
	logic [NUM_PU-1:0]         io_req;
	switch_info_pkg::io_cmd_t  io_cmd [NUM_PU];
	logic [NUM_PU-1:0]         io_ack;
	logic [DATA_NBITS-1:0]     io_ack_data [NUM_PU];
	switch_info_pkg::pio_req_t pio_req;
	switch_info_pkg::pio_rsp_t pio_rsp;

	logic [DATA_NBITS-1:0]    model [MEM_WORDS]; // Reference copy of the array
	switch_info_pkg::io_cmd_t cmd_buf [NUM_PU];
	logic [DEPTH_NBITS-1:0]   exp_addr [NUM_PU];
	int                       ack_order [$];
	logic [31:0]              rng;
	int                       errors, n_pass, n_fail;
	int                       cyc = 0;

	tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

	pu_switch_info_mem #(
		.NUM_PU      (NUM_PU),
		.DATA_NBITS  (DATA_NBITS),
		.DEPTH_NBITS (DEPTH_NBITS)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.io_req      (io_req),
		.io_cmd      (io_cmd),
		.io_ack      (io_ack),
		.io_ack_data (io_ack_data),
		.pio_req     (pio_req),
		.pio_rsp     (pio_rsp)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Run stopped at the cycle limit of %0d before the tests ended", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////
	function automatic logic [31:0] xorshift_next();
		logic [31:0] s;
		s = rng;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		rng = s;
		return s;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("ERROR %s", what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == 0) begin
			n_pass++;
			$display("PASS %s", name);
		end else begin
			n_fail++;
			$display("FAIL %s with %0d errors", name, errors);
		end
		errors = 0;
	endtask

	// Random entry for one PU; a bad command gets a wrong region code
	function automatic void set_cmd(input int pu, input logic [FID_NB-1:0] fid, input bit good);
		logic [31:0]       r;
		logic [IDX_NB-1:0] idx;
		logic [3:0]        region;
		r      = xorshift_next();
		idx    = r[IDX_NB-1:0];
		region = good ? switch_info_pkg::REGION_SWITCH_INFO
			: switch_info_pkg::REGION_SWITCH_INFO ^ (r[11:8] | 4'h1);
		cmd_buf[pu].fid  = fid;
		cmd_buf[pu].addr = {region, r[7:6], idx}; // Bits 7..6 are don't care
		exp_addr[pu]     = {fid, idx};
	endfunction

	task automatic pio_op(input switch_info_pkg::pio_op_e op, input logic [DEPTH_NBITS-1:0] addr,
			input logic [31:0] din, input string name);
		@(posedge clk);
		pio_req.op   <= op;
		pio_req.sel  <= 1'b1;
		pio_req.addr <= 32'(addr);
		pio_req.din  <= din;
		@(negedge clk);
		check_true(!pio_rsp.ack, "host ack arrived in the request cycle");
		@(posedge clk);
		pio_req <= '0;
		@(negedge clk);
		check_true(pio_rsp.ack, "host ack missing one cycle after the request");
		check_val(name, (op == switch_info_pkg::PIO_READ) ? model[addr] : 32'd0, pio_rsp.rdata);
		if (op == switch_info_pkg::PIO_WRITE)
			model[addr] = din;
	endtask

	// Strobe the PUs in req_mask together, watch acks at each falling edge
	task automatic serve(input string name, input logic [NUM_PU-1:0] req_mask,
			input logic [NUM_PU-1:0] ack_mask, input int min_lat, input int max_lat,
			input int window);
		int ack_cyc [NUM_PU];
		for (int i = 0; i < NUM_PU; i++)
			ack_cyc[i] = -1;
		ack_order.delete();
		@(posedge clk);
		io_req <= req_mask;
		for (int i = 0; i < NUM_PU; i++)
			io_cmd[i] <= cmd_buf[i];
		for (int c = 0; c < window; c++) begin
			@(negedge clk);
			for (int i = 0; i < NUM_PU; i++) begin
				if (io_ack[i]) begin
					check_true(ack_mask[i] && ack_cyc[i] < 0,
						$sformatf("unexpected acknowledge on PU %0d", i));
					check_true(c >= min_lat && c <= max_lat,
						$sformatf("PU %0d acknowledged after %0d cycles", i, c));
					check_val(name, model[exp_addr[i]], io_ack_data[i]);
					ack_cyc[i] = c;
					ack_order.push_back(i);
				end else begin
					check_val(name, 32'd0, io_ack_data[i]); // Idle data is zero
				end
			end
			@(posedge clk);
			io_req <= '0;
		end
		for (int i = 0; i < NUM_PU; i++)
			if (ack_mask[i])
				check_true(ack_cyc[i] >= 0, $sformatf("PU %0d was never acknowledged", i));
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic test_host_rw();
		for (int a = 0; a < MEM_WORDS; a++)
			pio_op(switch_info_pkg::PIO_WRITE, DEPTH_NBITS'(a), xorshift_next(), "host_rw");
		for (int a = 0; a < MEM_WORDS; a++)
			pio_op(switch_info_pkg::PIO_READ, DEPTH_NBITS'(a), 32'd0, "host_rw");
		finish_test("host_rw");
	endtask

	task automatic test_single_read();
		for (int p = 0; p < NUM_PU; p++)
			for (int n = 0; n < N_SINGLE; n++) begin
				set_cmd(p, FID_NB'(xorshift_next()), 1'b1);
				serve("single_read", ONE_PU << p, ONE_PU << p, LAT, LAT, WIN);
			end
		finish_test("single_read");
	endtask

	task automatic test_contention();
		int lead;
		int exp_pu;
		for (int r = 0; r < 4; r++) begin
			lead = int'(xorshift_next() % NUM_PU);
			set_cmd(lead, FID_NB'(xorshift_next()), 1'b1);
			serve("contention", ONE_PU << lead, ONE_PU << lead, LAT, LAT, WIN);
			for (int i = 0; i < NUM_PU; i++)
				set_cmd(i, FID_NB'(i), 1'b1); // Distinct fids, distinct addresses
			serve("contention", '1, '1, LAT, MAX_LAT, WIN);
			// Priority starts at the PU after the lead winner
			for (int k = 0; k < NUM_PU; k++) begin
				exp_pu = (lead + 1 + k) % NUM_PU;
				check_true(k < ack_order.size() && ack_order[k] == exp_pu,
					$sformatf("PU %0d missed its round-robin turn %0d", exp_pu, k));
			end
		end
		finish_test("contention");
	endtask

	task automatic test_region();
		for (int p = 0; p < NUM_PU; p++) begin
			set_cmd(p, FID_NB'(xorshift_next()), 1'b0);
			serve("region_filter", ONE_PU << p, '0, 0, 0, 10);
			set_cmd(p, FID_NB'(xorshift_next()), 1'b1);
			serve("region_filter", ONE_PU << p, ONE_PU << p, LAT, LAT, WIN);
		end
		finish_test("region_filter");
	endtask

	// Each PU re-requests right after its own ack
	task automatic test_stream();
		int                rounds [NUM_PU];
		int                wait_cyc [NUM_PU];
		logic [NUM_PU-1:0] busy;
		logic [NUM_PU-1:0] strobe;
		int                done;
		busy = '0;
		done = 0;
		for (int i = 0; i < NUM_PU; i++) begin
			rounds[i]   = 0;
			wait_cyc[i] = 0;
		end
		while (done < NUM_PU) begin
			@(posedge clk);
			strobe = '0;
			for (int i = 0; i < NUM_PU; i++)
				if (!busy[i] && rounds[i] < N_ROUNDS) begin
					set_cmd(i, FID_NB'(xorshift_next()), 1'b1);
					io_cmd[i]   <= cmd_buf[i];
					strobe[i]   = 1'b1;
					busy[i]     = 1'b1;
					wait_cyc[i] = 0;
				end
			io_req <= strobe;
			@(negedge clk);
			for (int i = 0; i < NUM_PU; i++) begin
				if (io_ack[i]) begin
					check_true(busy[i], $sformatf("PU %0d acknowledged with no request", i));
					check_true(wait_cyc[i] >= LAT && wait_cyc[i] <= MAX_LAT,
						$sformatf("PU %0d waited %0d cycles", i, wait_cyc[i]));
					check_val("stream", model[exp_addr[i]], io_ack_data[i]);
					busy[i] = 1'b0;
					rounds[i]++;
					if (rounds[i] == N_ROUNDS)
						done++;
				end else if (busy[i]) begin
					wait_cyc[i]++;
				end
			end
		end
		@(posedge clk);
		io_req <= '0;
		finish_test("stream");
	endtask

	initial begin
		io_req  = '0;
		pio_req = '0;
		for (int i = 0; i < NUM_PU; i++)
			io_cmd[i] = '0;
		rng    = 32'd92589;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		@(negedge rst);
		test_host_rw(); // Fills every word before the PU tests
		test_single_read();
		test_contention();
		test_region();
		test_stream();
		$display("Tests passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- switch_info.f
hdl/switch_info_pkg.sv
hdl/pu_req_latch.sv
hdl/pu_rr_arbiter.sv
hdl/switch_info_ram.sv
hdl/pu_resp_router.sv
hdl/pu_switch_info_mem.sv
tb/tb_clk_gen.sv
tb/tb_pu_switch_info_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then decide on the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f switch_info.f \
	--top-module tb_pu_switch_info_mem -Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log \
	|| echo "Build or simulation error"
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
